/* verilog/st_glue_pkg.sv */
// shared types and constants for the ST memory glue
// widths, control word bit map, viking window and apb offsets
// every glue module refers to these by scoped name
`default_nettype none

package st_glue_pkg;

	typedef logic [23:1]        word_addr_t;   // 68000 word address, a0 implied
	typedef logic [15:0]        data16_t;      // one memory word
	typedef logic [31:0]        ctrl_word_t;   // system control word
	typedef logic [9:0]         ym_sample_t;   // psg channel, unsigned
	typedef logic [7:0]         dma_sample_t;  // ste dma sound, unsigned
	typedef logic signed [14:0] mix_sample_t;  // signed mix for the dac
	typedef logic [1:0]         bus_phase_t;

	// bus cycle phases as driven by the mmu
	localparam bus_phase_t PHASE_CPU_PRE = 2'd0;
	localparam bus_phase_t PHASE_CPU     = 2'd1;
	localparam bus_phase_t PHASE_VIDEO   = 2'd2;  // shifter and viking share it

	// ram configs, field ctrl[3:1]
	typedef enum logic [2:0] {
		MEM_512K   = 3'd0,
		MEM_1M     = 3'd1,
		MEM_2M     = 3'd2,
		MEM_4M     = 3'd3,
		MEM_8M     = 3'd4,
		MEM_14M    = 3'd5,
		MEM_NONE_6 = 3'd6,  // no ram
		MEM_NONE_7 = 3'd7   // no ram
	} mem_size_t;

	typedef enum logic [1:0] {
		VK_IDLE     = 2'd0,
		VK_COUNTING = 2'd1,
		VK_ACTIVE   = 2'd2
	} viking_state_t;

	// control word bit positions
	localparam int CFG_RESET_BIT  = 0;   // core reset request
	localparam int CFG_MEM_LSB    = 1;   // mem size in bits 3..1
	localparam int CFG_STE_BIT    = 23;
	localparam int CFG_MSTE_BIT   = 24;
	localparam int CFG_VIKING_BIT = 28;

	// viking window, top six address bits
	localparam logic [5:0] VIKING_BASE_ST   = 6'b110000;  // $c00000
	localparam logic [5:0] VIKING_BASE_HI   = 6'b111010;  // $e80000
	localparam logic [7:0] VIKING_THRESHOLD = 8'd255;    // accesses before driver is trusted

	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_STATUS = 8'h04;

	localparam ym_sample_t  YM_OFFSET  = 10'd512;  // psg midpoint
	localparam dma_sample_t DMA_OFFSET = 8'd128;   // dma sound midpoint

endpackage

`default_nettype wire

/* verilog/st_sys_ctrl.sv */
// system control register on apb plus viking driver detection
// ctrl holds the system word, status reports the detector
// mode outputs are decoded straight from the register
`timescale 1ns/100ps
`default_nettype none

module st_sys_ctrl (
	input  wire                          clk_32,
	input  wire                          xsint,       // async reset, low active
	input  wire                          psel_i,
	input  wire                          penable_i,
	input  wire                          pwrite_i,
	input  wire [7:0]                    paddr_i,
	input  wire st_glue_pkg::ctrl_word_t pwdata_i,
	input  wire                          mhz8_en1_i,  // 8 MHz bus strobe
	input  wire                          as_n_i,
	input  wire st_glue_pkg::word_addr_t cpu_a_i,
	output logic [31:0]                  prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o,
	output st_glue_pkg::mem_size_t       mem_size_o,
	output logic                         viking_enable_o,
	output logic                         steroids_o,
	output logic                         viking_active_o
);

	st_glue_pkg::ctrl_word_t    ctrl_q;
	st_glue_pkg::viking_state_t vk_state;
	logic [7:0]                 vk_count;   // window accesses seen so far
	logic                       apb_access;
	logic                       ctrl_hit;
	logic                       status_hit;
	logic                       ctrl_wr;
	logic                       mem_ok;
	logic [5:0]                 vk_prefix;
	logic                       vk_hit;

	// apb, no wait states
	assign apb_access = psel_i & penable_i;
	assign ctrl_hit   = (paddr_i == st_glue_pkg::REG_CTRL);
	assign status_hit = (paddr_i == st_glue_pkg::REG_STATUS);
	assign ctrl_wr    = apb_access & pwrite_i & ctrl_hit;
	assign pready_o   = apb_access;
	assign pslverr_o  = apb_access & ((~ctrl_hit & ~status_hit) | (pwrite_i & status_hit));

	always_comb begin
		prdata_o = '0;  // unmapped reads return zero
		if (ctrl_hit)
			prdata_o = ctrl_q;
		else if (status_hit)
			prdata_o = {16'h0000, vk_count, 7'd0, viking_active_o};
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ctrl_q <= '0;  // 512K, plain ST, no viking
		else if (ctrl_wr)
			ctrl_q <= pwdata_i;
	end

	// ste on steroids needs both ste and mste bits
	assign steroids_o = ctrl_q[st_glue_pkg::CFG_STE_BIT] & ctrl_q[st_glue_pkg::CFG_MSTE_BIT];
	assign mem_size_o = st_glue_pkg::mem_size_t'(ctrl_q[st_glue_pkg::CFG_MEM_LSB +: 3]);

	// viking video memory collides with ram above 8M
	// steroids moves it to $e80000, so 14M is fine there
	assign mem_ok = (mem_size_o <= st_glue_pkg::MEM_8M);
	assign viking_enable_o = (ctrl_q[st_glue_pkg::CFG_VIKING_BIT] & mem_ok) | steroids_o;

	assign vk_prefix = steroids_o ? st_glue_pkg::VIKING_BASE_HI : st_glue_pkg::VIKING_BASE_ST;
	assign vk_hit    = mhz8_en1_i & ~as_n_i & viking_enable_o &
	                   (cpu_a_i[23:18] == vk_prefix);

	// plain probes of the window are common, so only a long run of
	// accesses means a driver is really using the card
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			vk_state <= st_glue_pkg::VK_IDLE;
			vk_count <= '0;
		end else if (ctrl_q[st_glue_pkg::CFG_RESET_BIT]) begin
			vk_state <= st_glue_pkg::VK_IDLE;  // core reset forgets the driver
			vk_count <= '0;
		end else begin
			case (vk_state)
				st_glue_pkg::VK_IDLE: begin
					if (vk_hit) begin
						vk_count <= vk_count + 8'd1;
						vk_state <= st_glue_pkg::VK_COUNTING;
					end
				end
				st_glue_pkg::VK_COUNTING: begin
					if (vk_count == st_glue_pkg::VIKING_THRESHOLD)
						vk_state <= st_glue_pkg::VK_ACTIVE;  // one clock after saturating
					else if (vk_hit)
						vk_count <= vk_count + 8'd1;
				end
				st_glue_pkg::VK_ACTIVE: begin
					vk_state <= st_glue_pkg::VK_ACTIVE;  // held until core reset
				end
				default: begin
					vk_state <= st_glue_pkg::VK_IDLE;
				end
			endcase
		end
	end

	assign viking_active_o = (vk_state == st_glue_pkg::VK_ACTIVE);

endmodule

`default_nettype wire

/* verilog/st_ram_window.sv */
// chipset ram address check
// high when the address hits configured st ram or the viking window
`timescale 1ns/100ps
`default_nettype none

module st_ram_window (
	input  wire st_glue_pkg::word_addr_t ram_a_i,
	input  wire st_glue_pkg::mem_size_t  mem_size_i,
	input  wire                          viking_enable_i,
	input  wire                          steroids_i,
	output logic                         ram_en_o
);

	logic below_top;   // address under the ram top
	logic in_viking;   // address inside enabled viking memory

	always_comb begin
		case (mem_size_i)
			st_glue_pkg::MEM_512K:   below_top = (ram_a_i[23:19] == 5'b00000);  // < $080000
			st_glue_pkg::MEM_1M:     below_top = (ram_a_i[23:20] == 4'b0000);   // < $100000
			st_glue_pkg::MEM_2M:     below_top = (ram_a_i[23:21] == 3'b000);    // < $200000
			st_glue_pkg::MEM_4M:     below_top = (ram_a_i[23:22] == 2'b00);     // < $400000
			st_glue_pkg::MEM_8M:     below_top = ~ram_a_i[23];                 // < $800000
			st_glue_pkg::MEM_14M:    below_top = (ram_a_i[23:21] != 3'b111);    // < $e00000
			st_glue_pkg::MEM_NONE_6: below_top = 1'b0;
			st_glue_pkg::MEM_NONE_7: below_top = 1'b0;
			default:                 below_top = 1'b0;
		endcase
	end

	// 256K at $c00000 normally, 512K at $e80000 in steroids mode
	always_comb begin
		in_viking = 1'b0;
		if (viking_enable_i) begin
			if (steroids_i)
				in_viking = (ram_a_i[23:19] == st_glue_pkg::VIKING_BASE_HI[5:1]);
			else
				in_viking = (ram_a_i[23:18] == st_glue_pkg::VIKING_BASE_ST);
		end
	end

	assign ram_en_o = below_top | in_viking;

endmodule

`default_nettype wire

/* verilog/st_bus_mux.sv */
// sdram request mux between upload, blitter, viking fetch and mmu
// one request per bus phase, outputs are combinational except for
// the ras sample and the upload write pulse
`timescale 1ns/100ps
`default_nettype none

module st_bus_mux (
	input  wire                          clk_32,
	input  wire                          xsint,
	input  wire st_glue_pkg::bus_phase_t bus_cycle_i,
	input  wire                          mhz8_en1_i,
	input  wire st_glue_pkg::word_addr_t ram_a_i,
	input  wire                          ras_n_i,
	input  wire                          ram_we_n_i,
	input  wire                          ram_uds_i,
	input  wire                          ram_lds_i,
	input  wire st_glue_pkg::data16_t    ram_din_i,
	input  wire                          ram_en_i,
	input  wire                          dl_active_i,   // upload in progress
	input  wire st_glue_pkg::word_addr_t dl_addr_i,
	input  wire st_glue_pkg::data16_t    dl_data_i,
	input  wire                          dl_strobe_i,   // toggles per word
	input  wire                          bm_has_bus_i,
	input  wire st_glue_pkg::word_addr_t bm_addr_i,
	input  wire st_glue_pkg::data16_t    bm_data_i,
	input  wire                          bm_read_i,
	input  wire                          bm_write_i,
	input  wire                          viking_active_i,
	input  wire st_glue_pkg::word_addr_t vk_addr_i,
	input  wire                          vk_read_i,
	output st_glue_pkg::word_addr_t      sdram_addr_o,
	output st_glue_pkg::data16_t         sdram_din_o,
	output logic                         sdram_oe_o,
	output logic                         sdram_we_o,
	output logic                         sdram_uds_o,
	output logic                         sdram_lds_o
);

	logic cpu_precycle;
	logic cpu_cycle;
	logic video_cycle;
	logic ras_n_d;     // ras_n one clock back
	logic strobe_d;    // last sampled dl_strobe
	logic upload_wr;   // one clock write pulse per uploaded word
	logic ram_oe;
	logic ram_we;

	assign cpu_precycle = (bus_cycle_i == st_glue_pkg::PHASE_CPU_PRE);
	assign cpu_cycle    = (bus_cycle_i == st_glue_pkg::PHASE_CPU);
	assign video_cycle  = (bus_cycle_i == st_glue_pkg::PHASE_VIDEO);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d   <= 1'b1;
			strobe_d  <= 1'b0;
			upload_wr <= 1'b0;
		end else begin
			ras_n_d   <= ras_n_i;
			upload_wr <= 1'b0;
			// strobe sampled in the precycle so the write lands in the cpu slot
			if (cpu_precycle && mhz8_en1_i) begin
				strobe_d <= dl_strobe_i;
				if (dl_strobe_i != strobe_d)
					upload_wr <= 1'b1;
			end
		end
	end

	// chipset request starts on the falling ras edge
	assign ram_oe = ras_n_d & ~ras_n_i & ram_we_n_i & (|ram_a_i);  // address 0 never read
	assign ram_we = ras_n_d & ~ras_n_i & ~ram_we_n_i;

	always_comb begin
		sdram_addr_o = ram_a_i;          // chipset by default
		sdram_oe_o   = ram_oe & ram_en_i;
		sdram_we_o   = ram_we & ram_en_i;
		sdram_uds_o  = ram_uds_i;
		sdram_lds_o  = ram_lds_i;
		if (cpu_cycle && dl_active_i) begin
			sdram_addr_o = dl_addr_i;    // upload owns the cpu slot
			sdram_oe_o   = 1'b0;
			sdram_we_o   = upload_wr;
			sdram_uds_o  = 1'b1;
			sdram_lds_o  = 1'b1;
		end else if (cpu_cycle && bm_has_bus_i) begin
			sdram_addr_o = bm_addr_i;    // blitter, full words only
			sdram_oe_o   = bm_read_i;
			sdram_we_o   = bm_write_i;
			sdram_uds_o  = 1'b1;
			sdram_lds_o  = 1'b1;
		end else if (video_cycle && viking_active_i && vk_read_i) begin
			sdram_addr_o = vk_addr_i;    // viking takes the shifter slot
			sdram_oe_o   = 1'b1;
			sdram_we_o   = 1'b0;
		end
	end

	assign sdram_din_o = dl_active_i  ? dl_data_i :
	                     bm_has_bus_i ? bm_data_i : ram_din_i;

endmodule

`default_nettype wire

/* verilog/st_audio_mix.sv */
// psg plus ste dma sound mixer, one registered 15 bit sum per side
// samples are centred, widened to 15 bits and added
`timescale 1ns/100ps
`default_nettype none

module st_audio_mix (
	input  wire                           clk_32,
	input  wire                           xsint,
	input  wire st_glue_pkg::ym_sample_t  ym_l_i,
	input  wire st_glue_pkg::ym_sample_t  ym_r_i,
	input  wire st_glue_pkg::dma_sample_t dma_l_i,
	input  wire st_glue_pkg::dma_sample_t dma_r_i,
	output st_glue_pkg::mix_sample_t      mix_l_o,
	output st_glue_pkg::mix_sample_t      mix_r_o
);

	// low bits repeat the top bits so full scale stays near full scale
	function automatic st_glue_pkg::mix_sample_t widen_add(
		input st_glue_pkg::ym_sample_t  ym,
		input st_glue_pkg::dma_sample_t dma
	);
		st_glue_pkg::ym_sample_t  ym_s;
		st_glue_pkg::dma_sample_t dma_s;
		ym_s  = ym - st_glue_pkg::YM_OFFSET;    // now two's complement
		dma_s = dma - st_glue_pkg::DMA_OFFSET;
		return {ym_s[9], ym_s, ym_s[9:6]} + {dma_s[7], dma_s, dma_s[7:2]};  // wraps at 15 bits
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= widen_add(ym_l_i, dma_l_i);
			mix_r_o <= widen_add(ym_r_i, dma_r_i);
		end
	end

endmodule

`default_nettype wire

/* verilog/st_glue_top.sv */
// memory side glue of the ST core
// apb control register, ram window decode, sdram request mux
// and audio mixer, wired together here
`timescale 1ns/100ps
`default_nettype none

module st_glue_top (
	input  wire                           clk_32,
	input  wire                           xsint,
	input  wire                           psel_i,
	input  wire                           penable_i,
	input  wire                           pwrite_i,
	input  wire [7:0]                     paddr_i,
	input  wire st_glue_pkg::ctrl_word_t  pwdata_i,
	output logic [31:0]                   prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,
	input  wire st_glue_pkg::bus_phase_t  bus_cycle_i,
	input  wire                           mhz8_en1_i,
	input  wire st_glue_pkg::word_addr_t  cpu_a_i,
	input  wire                           as_n_i,
	input  wire st_glue_pkg::word_addr_t  ram_a_i,
	input  wire                           ras_n_i,
	input  wire                           ram_we_n_i,
	input  wire                           ram_uds_i,
	input  wire                           ram_lds_i,
	input  wire st_glue_pkg::data16_t     ram_din_i,
	input  wire                           dl_active_i,
	input  wire st_glue_pkg::word_addr_t  dl_addr_i,
	input  wire st_glue_pkg::data16_t     dl_data_i,
	input  wire                           dl_strobe_i,
	input  wire                           bm_has_bus_i,
	input  wire st_glue_pkg::word_addr_t  bm_addr_i,
	input  wire st_glue_pkg::data16_t     bm_data_i,
	input  wire                           bm_read_i,
	input  wire                           bm_write_i,
	input  wire st_glue_pkg::word_addr_t  vk_addr_i,
	input  wire                           vk_read_i,
	output st_glue_pkg::word_addr_t       sdram_addr_o,
	output st_glue_pkg::data16_t          sdram_din_o,
	output logic                          sdram_oe_o,
	output logic                          sdram_we_o,
	output logic                          sdram_uds_o,
	output logic                          sdram_lds_o,
	input  wire st_glue_pkg::ym_sample_t  ym_l_i,
	input  wire st_glue_pkg::ym_sample_t  ym_r_i,
	input  wire st_glue_pkg::dma_sample_t dma_l_i,
	input  wire st_glue_pkg::dma_sample_t dma_r_i,
	output st_glue_pkg::mix_sample_t      mix_l_o,
	output st_glue_pkg::mix_sample_t      mix_r_o
);

	wire st_glue_pkg::mem_size_t mem_size;
	wire viking_enable;
	wire steroids;
	wire viking_active;   // driver detected, viking owns video slot
	wire ram_en;

	st_sys_ctrl u_sys_ctrl (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.psel_i          (psel_i),
		.penable_i       (penable_i),
		.pwrite_i        (pwrite_i),
		.paddr_i         (paddr_i),
		.pwdata_i        (pwdata_i),
		.mhz8_en1_i      (mhz8_en1_i),
		.as_n_i          (as_n_i),
		.cpu_a_i         (cpu_a_i),
		.prdata_o        (prdata_o),
		.pready_o        (pready_o),
		.pslverr_o       (pslverr_o),
		.mem_size_o      (mem_size),
		.viking_enable_o (viking_enable),
		.steroids_o      (steroids),
		.viking_active_o (viking_active)
	);

	st_ram_window u_ram_window (
		.ram_a_i         (ram_a_i),
		.mem_size_i      (mem_size),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids),
		.ram_en_o        (ram_en)
	);

	st_bus_mux u_bus_mux (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.bus_cycle_i     (bus_cycle_i),
		.mhz8_en1_i      (mhz8_en1_i),
		.ram_a_i         (ram_a_i),
		.ras_n_i         (ras_n_i),
		.ram_we_n_i      (ram_we_n_i),
		.ram_uds_i       (ram_uds_i),
		.ram_lds_i       (ram_lds_i),
		.ram_din_i       (ram_din_i),
		.ram_en_i        (ram_en),
		.dl_active_i     (dl_active_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_strobe_i     (dl_strobe_i),
		.bm_has_bus_i    (bm_has_bus_i),
		.bm_addr_i       (bm_addr_i),
		.bm_data_i       (bm_data_i),
		.bm_read_i       (bm_read_i),
		.bm_write_i      (bm_write_i),
		.viking_active_i (viking_active),
		.vk_addr_i       (vk_addr_i),
		.vk_read_i       (vk_read_i),
		.sdram_addr_o    (sdram_addr_o),
		.sdram_din_o     (sdram_din_o),
		.sdram_oe_o      (sdram_oe_o),
		.sdram_we_o      (sdram_we_o),
		.sdram_uds_o     (sdram_uds_o),
		.sdram_lds_o     (sdram_lds_o)
	);

	st_audio_mix u_audio_mix (
		.clk_32  (clk_32),
		.xsint   (xsint),
		.ym_l_i  (ym_l_i),
		.ym_r_i  (ym_r_i),
		.dma_l_i (dma_l_i),
		.dma_r_i (dma_r_i),
		.mix_l_o (mix_l_o),
		.mix_r_o (mix_r_o)
	);

endmodule

`default_nettype wire

/* verification/st_glue_assertions.sv */
// protocol and sdram request rules on the glue top level
// attached to every st_glue_top instance through bind
`timescale 1ns/100ps
`default_nettype none

module st_glue_assertions (
	input wire       clk_32,
	input wire       xsint,
	input wire       psel_i,
	input wire       penable_i,
	input wire       pwrite_i,
	input wire [7:0] paddr_i,
	input wire       pready_i,
	input wire       sdram_oe_i,
	input wire       sdram_we_i,
	input wire       viking_active_i
);

	wire ctrl_wr;  // control register write in its access phase

	assign ctrl_wr = psel_i & penable_i & pwrite_i & (paddr_i == st_glue_pkg::REG_CTRL);

	// zero wait states
	ap_pready: assert property (@(posedge clk_32) disable iff (!xsint)
		(psel_i && penable_i) |-> pready_i)
		else $error("pready low in an APB access phase");

	ap_oe_we: assert property (@(posedge clk_32) disable iff (!xsint)
		!(sdram_oe_i && sdram_we_i))
		else $error("sdram read and write requested together");

	// reset bit lands one clock after the write, the detector clears one later
	ap_viking_hold: assert property (@(posedge clk_32) disable iff (!xsint)
		$fell(viking_active_i) |-> ($past(ctrl_wr) || $past(ctrl_wr, 2)))
		else $error("viking_active dropped without a control write");

endmodule

bind st_glue_top st_glue_assertions u_assertions (
	.clk_32          (clk_32),
	.xsint           (xsint),
	.psel_i          (psel_i),
	.penable_i       (penable_i),
	.pwrite_i        (pwrite_i),
	.paddr_i         (paddr_i),
	.pready_i        (pready_o),
	.sdram_oe_i      (sdram_oe_o),
	.sdram_we_i      (sdram_we_o),
	.viking_active_i (viking_active)
);

`default_nettype wire

/* verification/st_glue_tb.sv */
// directed testbench for the ST memory glue top level
// drives apb, chipset, upload, blitter, viking and audio inputs
// on falling edges and checks responses after they settle
`timescale 1ns/100ps
`default_nettype none

module st_glue_tb;

	logic                       clk_32;
	logic                       xsint;
	logic                       psel_i;
	logic                       penable_i;
	logic                       pwrite_i;
	logic [7:0]                 paddr_i;
	st_glue_pkg::ctrl_word_t    pwdata_i;
	logic [31:0]                prdata_o;
	logic                       pready_o;
	logic                       pslverr_o;
	st_glue_pkg::bus_phase_t    bus_cycle_i;
	logic                       mhz8_en1_i;
	st_glue_pkg::word_addr_t    cpu_a_i;
	logic                       as_n_i;
	st_glue_pkg::word_addr_t    ram_a_i;
	logic                       ras_n_i;
	logic                       ram_we_n_i;
	logic                       ram_uds_i;
	logic                       ram_lds_i;
	st_glue_pkg::data16_t       ram_din_i;
	logic                       dl_active_i;
	st_glue_pkg::word_addr_t    dl_addr_i;
	st_glue_pkg::data16_t       dl_data_i;
	logic                       dl_strobe_i;
	logic                       bm_has_bus_i;
	st_glue_pkg::word_addr_t    bm_addr_i;
	st_glue_pkg::data16_t       bm_data_i;
	logic                       bm_read_i;
	logic                       bm_write_i;
	st_glue_pkg::word_addr_t    vk_addr_i;
	logic                       vk_read_i;
	st_glue_pkg::word_addr_t    sdram_addr_o;
	st_glue_pkg::data16_t       sdram_din_o;
	logic                       sdram_oe_o;
	logic                       sdram_we_o;
	logic                       sdram_uds_o;
	logic                       sdram_lds_o;
	st_glue_pkg::ym_sample_t    ym_l_i;
	st_glue_pkg::ym_sample_t    ym_r_i;
	st_glue_pkg::dma_sample_t   dma_l_i;
	st_glue_pkg::dma_sample_t   dma_r_i;
	st_glue_pkg::mix_sample_t   mix_l_o;
	st_glue_pkg::mix_sample_t   mix_r_o;

	integer seed;
	int     errors;
	int     checks;

	st_glue_top dut (
		.clk_32(clk_32), .xsint(xsint),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o),
		.bus_cycle_i(bus_cycle_i), .mhz8_en1_i(mhz8_en1_i),
		.cpu_a_i(cpu_a_i), .as_n_i(as_n_i),
		.ram_a_i(ram_a_i), .ras_n_i(ras_n_i), .ram_we_n_i(ram_we_n_i),
		.ram_uds_i(ram_uds_i), .ram_lds_i(ram_lds_i), .ram_din_i(ram_din_i),
		.dl_active_i(dl_active_i), .dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i), .dl_strobe_i(dl_strobe_i),
		.bm_has_bus_i(bm_has_bus_i), .bm_addr_i(bm_addr_i), .bm_data_i(bm_data_i),
		.bm_read_i(bm_read_i), .bm_write_i(bm_write_i),
		.vk_addr_i(vk_addr_i), .vk_read_i(vk_read_i),
		.sdram_addr_o(sdram_addr_o), .sdram_din_o(sdram_din_o),
		.sdram_oe_o(sdram_oe_o), .sdram_we_o(sdram_we_o),
		.sdram_uds_o(sdram_uds_o), .sdram_lds_o(sdram_lds_o),
		.ym_l_i(ym_l_i), .ym_r_i(ym_r_i), .dma_l_i(dma_l_i), .dma_r_i(dma_r_i),
		.mix_l_o(mix_l_o), .mix_r_o(mix_r_o)
	);

	always #5 clk_32 = ~clk_32;  // 10 ns period

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// called right at the falling edge where the setup phase starts
	task automatic apb_transfer(input logic [7:0] addr, input logic wr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = addr;
		pwdata_i  = wdata;
		@(negedge clk_32);
		penable_i = 1'b1;  // access phase
		#1;
		n = 0;
		while (!pready_o && n < 16) begin
			@(negedge clk_32);
			#1;
			n++;
		end
		if (!pready_o) begin
			$display("APB timeout, pready never rose at offset %h", addr);
			errors++;
		end
		rdata = prdata_o;
		err   = pslverr_o;
		@(negedge clk_32);
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rd;
		@(negedge clk_32);
		apb_transfer(addr, 1'b1, data, unused_rd, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk_32);
		apb_transfer(addr, 1'b0, 32'd0, data, err);
	endtask

	function automatic st_glue_pkg::word_addr_t to_word(input logic [23:0] byte_a);
		return byte_a[23:1];
	endfunction

	function automatic logic [23:0] ram_top(input int size);
		case (size)
			0:       return 24'h080000;
			1:       return 24'h100000;
			2:       return 24'h200000;
			3:       return 24'h400000;
			4:       return 24'h800000;
			default: return 24'hE00000;  // 14M
		endcase
	endfunction

	// chipset read, ras_n high for one clock then falling
	task automatic chip_read(input st_glue_pkg::word_addr_t addr, output logic oe);
		@(negedge clk_32);
		ram_a_i    = addr;
		ras_n_i    = 1'b1;
		ram_we_n_i = 1'b1;
		@(negedge clk_32);
		ras_n_i = 1'b0;
		#1 oe = sdram_oe_o;
		@(negedge clk_32);
		ras_n_i = 1'b1;
	endtask

	task automatic window_access(input st_glue_pkg::word_addr_t addr);
		@(negedge clk_32);
		as_n_i     = 1'b0;
		mhz8_en1_i = 1'b1;
		cpu_a_i    = addr;
		@(negedge clk_32);
		as_n_i     = 1'b1;
		mhz8_en1_i = 1'b0;
	endtask

	// centre, widen to 15 bits and add, wrapping at 15 bits
	function automatic logic [14:0] mix_model(input int ym, input int dma);
		int ys;
		int ds;
		int s;
		ys = ym - 512;
		ds = dma - 128;
		s  = ys * 16 + ((ys + 1024) % 1024) / 64 + ds * 64 + ((ds + 256) % 256) / 4;
		return s[14:0];
	endfunction

	task automatic register_access;
		logic [31:0] rd;
		logic [31:0] word;
		logic        err;
		check_eq("reset sdram_we", 32'd0, 32'(sdram_we_o));
		check_eq("reset mix_l", 32'd0, {17'd0, mix_l_o});
		check_eq("reset mix_r", 32'd0, {17'd0, mix_r_o});
		apb_read(st_glue_pkg::REG_CTRL, rd, err);
		check_eq("reset ctrl", 32'd0, rd);
		check_eq("ctrl read pslverr", 32'd0, 32'(err));
		apb_read(st_glue_pkg::REG_STATUS, rd, err);
		check_eq("reset status", 32'd0, rd);
		word = $random(seed);
		apb_write(st_glue_pkg::REG_CTRL, word, err);
		apb_read(st_glue_pkg::REG_CTRL, rd, err);
		check_eq("ctrl readback", word, rd);
		apb_read(8'h10, rd, err);  // nothing mapped there
		check_eq("undefined offset pslverr", 32'd1, 32'(err));
		apb_write(st_glue_pkg::REG_STATUS, 32'hFFFF_FFFF, err);
		check_eq("status write pslverr", 32'd1, 32'(err));
	endtask

	task automatic ram_window_bounds;
		logic        oe;
		logic        err;
		logic [23:0] top;
		for (int s = 0; s < 6; s++) begin
			top = ram_top(s);
			apb_write(st_glue_pkg::REG_CTRL, 32'(s) << st_glue_pkg::CFG_MEM_LSB, err);
			chip_read(to_word(top - 24'd2), oe);
			check_eq($sformatf("last word below top, size %0d", s), 32'd1, 32'(oe));
			chip_read(to_word(top), oe);
			check_eq($sformatf("first word at top, size %0d", s), 32'd0, 32'(oe));
		end
		// viking window at $c00000 with 8M configured
		apb_write(st_glue_pkg::REG_CTRL, (32'd1 << st_glue_pkg::CFG_VIKING_BIT) | 32'h8, err);
		chip_read(to_word(24'hC00000), oe);
		check_eq("viking base", 32'd1, 32'(oe));
		chip_read(to_word(24'hC3FFFE), oe);
		check_eq("viking last word", 32'd1, 32'(oe));
		chip_read(to_word(24'hC40000), oe);
		check_eq("viking past end", 32'd0, 32'(oe));
		// steroids moves the 512K window to $e80000 above 14M
		apb_write(st_glue_pkg::REG_CTRL, (32'd1 << st_glue_pkg::CFG_VIKING_BIT) |
			(32'd1 << st_glue_pkg::CFG_STE_BIT) | (32'd1 << st_glue_pkg::CFG_MSTE_BIT) |
			32'hA, err);
		chip_read(to_word(24'hE80000), oe);
		check_eq("steroids base", 32'd1, 32'(oe));
		chip_read(to_word(24'hEFFFFE), oe);
		check_eq("steroids last word", 32'd1, 32'(oe));
		chip_read(to_word(24'hF00000), oe);
		check_eq("steroids past end", 32'd0, 32'(oe));
		chip_read(to_word(24'hE7FFFE), oe);
		check_eq("steroids below base", 32'd0, 32'(oe));
	endtask

	task automatic viking_detection;
		logic [31:0]             rd;
		logic                    err;
		st_glue_pkg::word_addr_t ra;
		apb_write(st_glue_pkg::REG_CTRL, 32'd1, err);  // clear detector
		apb_write(st_glue_pkg::REG_CTRL, (32'd1 << st_glue_pkg::CFG_VIKING_BIT) | 32'h8, err);
		repeat (254) window_access({6'b110000, 17'($random(seed))});
		apb_read(st_glue_pkg::REG_STATUS, rd, err);
		check_eq("status after 254 accesses", 32'h0000_FE00, rd);
		// access 255 overlaps the status setup phase and stays held through it
		@(negedge clk_32);
		as_n_i     = 1'b0;
		mhz8_en1_i = 1'b1;
		cpu_a_i    = {6'b110000, 17'($random(seed))};
		apb_transfer(st_glue_pkg::REG_STATUS, 1'b0, 32'd0, rd, err);
		as_n_i     = 1'b1;
		mhz8_en1_i = 1'b0;
		check_eq("status at threshold", 32'h0000_FF00, rd);
		apb_read(st_glue_pkg::REG_STATUS, rd, err);
		check_eq("status active", 32'h0000_FF01, rd);
		vk_addr_i = st_glue_pkg::word_addr_t'($random(seed));
		ra        = st_glue_pkg::word_addr_t'($random(seed));
		@(negedge clk_32);
		ram_a_i     = ra;
		bus_cycle_i = st_glue_pkg::PHASE_VIDEO;
		vk_read_i   = 1'b1;
		#1;
		check_eq("viking fetch addr", 32'(vk_addr_i), 32'(sdram_addr_o));
		check_eq("viking fetch oe", 32'd1, 32'(sdram_oe_o));
		@(negedge clk_32);
		bus_cycle_i = st_glue_pkg::PHASE_CPU;
		#1 check_eq("cpu cycle passes ram_a", 32'(ra), 32'(sdram_addr_o));
		@(negedge clk_32);
		bus_cycle_i = st_glue_pkg::PHASE_CPU_PRE;
		vk_read_i   = 1'b0;
		apb_write(st_glue_pkg::REG_CTRL, 32'd1, err);  // core reset forgets the driver
		apb_read(st_glue_pkg::REG_STATUS, rd, err);
		check_eq("status after core reset", 32'd0, rd);
		apb_write(st_glue_pkg::REG_CTRL, 32'd0, err);
	endtask

	task automatic mux_priority;
		dl_addr_i = st_glue_pkg::word_addr_t'($random(seed));
		dl_data_i = st_glue_pkg::data16_t'($random(seed));
		bm_addr_i = st_glue_pkg::word_addr_t'($random(seed));
		bm_data_i = st_glue_pkg::data16_t'($random(seed));
		@(negedge clk_32);
		bus_cycle_i  = st_glue_pkg::PHASE_CPU;
		dl_active_i  = 1'b1;
		bm_has_bus_i = 1'b1;  // upload still wins
		bm_read_i    = 1'b1;
		#1;
		check_eq("upload addr", 32'(dl_addr_i), 32'(sdram_addr_o));
		check_eq("upload data", 32'(dl_data_i), 32'(sdram_din_o));
		check_eq("upload strobes", 32'd3, {30'd0, sdram_uds_o, sdram_lds_o});
		check_eq("upload no read", 32'd0, 32'(sdram_oe_o));
		check_eq("upload idle we", 32'd0, 32'(sdram_we_o));
		@(negedge clk_32);
		bus_cycle_i = st_glue_pkg::PHASE_CPU_PRE;
		mhz8_en1_i  = 1'b1;
		dl_strobe_i = ~dl_strobe_i;  // one new word
		#1 check_eq("precycle we", 32'd0, 32'(sdram_we_o));
		@(negedge clk_32);
		bus_cycle_i = st_glue_pkg::PHASE_CPU;
		mhz8_en1_i  = 1'b0;
		#1 check_eq("upload we pulse", 32'd1, 32'(sdram_we_o));
		@(negedge clk_32);
		#1 check_eq("upload we single", 32'd0, 32'(sdram_we_o));
		@(negedge clk_32);
		dl_active_i = 1'b0;
		#1;
		check_eq("blitter addr", 32'(bm_addr_i), 32'(sdram_addr_o));
		check_eq("blitter data", 32'(bm_data_i), 32'(sdram_din_o));
		check_eq("blitter oe", 32'd1, 32'(sdram_oe_o));
		check_eq("blitter we", 32'd0, 32'(sdram_we_o));
		@(negedge clk_32);
		bus_cycle_i  = st_glue_pkg::PHASE_CPU_PRE;
		bm_has_bus_i = 1'b0;
		bm_read_i    = 1'b0;
	endtask

	task automatic audio_mixing;
		repeat (8) begin
			@(negedge clk_32);
			ym_l_i  = st_glue_pkg::ym_sample_t'($random(seed));
			ym_r_i  = st_glue_pkg::ym_sample_t'($random(seed));
			dma_l_i = st_glue_pkg::dma_sample_t'($random(seed));
			dma_r_i = st_glue_pkg::dma_sample_t'($random(seed));
			@(negedge clk_32);  // one clock of latency
			#1;
			check_eq("mix left", {17'd0, mix_model(ym_l_i, dma_l_i)}, {17'd0, mix_l_o});
			check_eq("mix right", {17'd0, mix_model(ym_r_i, dma_r_i)}, {17'd0, mix_r_o});
		end
	endtask

	initial begin
		seed         = 32'h64aa;
		errors       = 0;
		checks       = 0;
		clk_32       = 1'b0;
		xsint        = 1'b0;
		psel_i       = 1'b0;
		penable_i    = 1'b0;
		pwrite_i     = 1'b0;
		paddr_i      = '0;
		pwdata_i     = '0;
		bus_cycle_i  = st_glue_pkg::PHASE_CPU_PRE;
		mhz8_en1_i   = 1'b0;
		cpu_a_i      = '0;
		as_n_i       = 1'b1;
		ram_a_i      = '0;
		ras_n_i      = 1'b1;
		ram_we_n_i   = 1'b1;
		ram_uds_i    = 1'b0;
		ram_lds_i    = 1'b0;
		ram_din_i    = '0;
		dl_active_i  = 1'b0;
		dl_addr_i    = '0;
		dl_data_i    = '0;
		dl_strobe_i  = 1'b0;
		bm_has_bus_i = 1'b0;
		bm_addr_i    = '0;
		bm_data_i    = '0;
		bm_read_i    = 1'b0;
		bm_write_i   = 1'b0;
		vk_addr_i    = '0;
		vk_read_i    = 1'b0;
		ym_l_i       = '0;
		ym_r_i       = '0;
		dma_l_i      = '0;
		dma_r_i      = '0;
		repeat (4) @(posedge clk_32);
		@(negedge clk_32);
		xsint = 1'b1;
		register_access();
		ram_window_bounds();
		viking_detection();
		mux_priority();
		audio_mixing();
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/st_glue_pkg.sv
verilog/st_sys_ctrl.sv
verilog/st_ram_window.sv
verilog/st_bus_mux.sv
verilog/st_audio_mix.sv
verilog/st_glue_top.sv
verification/st_glue_assertions.sv
verification/st_glue_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module st_glue_tb -o st_glue_sim
out=$(./obj_dir/st_glue_sim) || true
echo "$out"
if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1
